/* source/b2b_pkg.sv */
package b2b_pkg;

	localparam int BYTE_W = 8;
	localparam int BIT_CNT_W = $clog2(BYTE_W);
	localparam int MATCH_W = 9;  // Wide enough to reach 256

	localparam logic [MATCH_W-1:0] DENSE_THRESHOLD = MATCH_W'(256);
	localparam logic [MATCH_W-1:0] SPARSE_THRESHOLD = MATCH_W'(64);

	// First received byte that switches sparse mode to the +2 convention
	localparam logic [BYTE_W-1:0] OFFSET_MARKER = 8'h02;

	localparam logic [BYTE_W-1:0] DENSE_TX_START = 8'hFF;  // First byte out is FE
	localparam logic [BYTE_W-1:0] SPARSE_TX_START = 8'h01;

	// Raw pads from the connector
	typedef struct packed {
		logic sck;
		logic ssel;  // Active low
		logic mosi;
	} spi_pins_t;

	// Synchronized pins, one-cycle strobes except frame_active and mosi_bit
	typedef struct packed {
		logic sck_rise;
		logic sck_fall;
		logic frame_active;
		logic frame_start;
		logic frame_end;
		logic mosi_bit;
	} spi_events_t;

	typedef struct packed {
		logic valid;  // Single-cycle pulse
		logic [BYTE_W-1:0] data;
	} rx_byte_t;

endpackage

/* source/spi_pin_sync.sv */
`timescale 1ns/10ps

module spi_pin_sync (
	input  logic                 clk,
	input  logic                 rst_n,
	input  b2b_pkg::spi_pins_t   pins,
	output b2b_pkg::spi_events_t events
);

	logic [2:0] sck_r;
	logic [2:0] ssel_r;
	logic [1:0] mosi_r;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sck_r <= 3'b000;
			ssel_r <= 3'b111;  // Deselected
		end else begin
			sck_r <= {sck_r[1:0], pins.sck};
			ssel_r <= {ssel_r[1:0], pins.ssel};
		end
	end

	// Data bit has the same two-flop delay as the edge decode
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mosi_r <= 2'b00;
		end else begin
			mosi_r <= {mosi_r[0], pins.mosi};
		end
	end

	always_comb begin
		events.sck_rise = (sck_r[2:1] == 2'b01);
		events.sck_fall = (sck_r[2:1] == 2'b10);
		events.frame_active = ~ssel_r[1];
		events.frame_start = (ssel_r[2:1] == 2'b10);  // ssel falling
		events.frame_end = (ssel_r[2:1] == 2'b01);
		events.mosi_bit = mosi_r[1];
	end

	// Frame edges stay clear of sck edges
	a_frame_edge_sck_quiet: assert property (
		@(posedge clk) disable iff (!rst_n)
		(events.frame_start || events.frame_end) |-> !(events.sck_rise || events.sck_fall)
	);

endmodule

/* source/spi_byte_engine.sv */
`timescale 1ns/10ps

module spi_byte_engine (
	input  logic                               clk,
	input  logic                               rst_n,
	input  b2b_pkg::spi_events_t               events,
	input  logic [b2b_pkg::BYTE_W-1:0]         tx_data,
	output b2b_pkg::rx_byte_t                  rx,
	output logic                               tx_load,
	output logic                               miso
);

	logic [b2b_pkg::BIT_CNT_W-1:0] bit_cnt;
	logic [b2b_pkg::BYTE_W-1:0] rx_shift;
	logic [b2b_pkg::BYTE_W-1:0] tx_shift;
	logic rx_valid;
	logic bit_in;
	logic bit_out;
	logic last_bit;

	assign bit_in = events.frame_active && events.sck_rise;
	assign bit_out = events.frame_active && events.sck_fall;
	assign last_bit = (bit_cnt == b2b_pkg::BIT_CNT_W'(b2b_pkg::BYTE_W - 1));

	// First fall of a byte fetches the next transmit value
	assign tx_load = bit_out && (bit_cnt == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt <= '0;
		end else if (!events.frame_active) begin
			bit_cnt <= '0;
		end else if (bit_in) begin
			bit_cnt <= bit_cnt + 1'b1;  // Wraps after bit 7
		end
	end

	// MSB first
	always_ff @(posedge clk) begin
		if (bit_in) begin
			rx_shift <= {rx_shift[b2b_pkg::BYTE_W-2:0], events.mosi_bit};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= bit_in && last_bit;  // Lands with the final shift
		end
	end

	assign rx.valid = rx_valid;
	assign rx.data = rx_shift;

	// Idle line is high until the first load
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tx_shift <= '1;
		end else if (tx_load) begin
			tx_shift <= tx_data;
		end else if (bit_out) begin
			tx_shift <= {tx_shift[b2b_pkg::BYTE_W-2:0], 1'b0};
		end
	end

	assign miso = tx_shift[b2b_pkg::BYTE_W-1];

	// Frames close on a byte boundary
	a_frame_end_aligned: assert property (
		@(posedge clk) disable iff (!rst_n)
		events.frame_end |-> (bit_cnt == '0)
	);

endmodule

/* source/rx_pattern_checker.sv */
`timescale 1ns/10ps

module rx_pattern_checker (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              mode,
	input  b2b_pkg::rx_byte_t rx,
	output logic              offset_mode,
	output logic              link_ok
);

	logic [b2b_pkg::BYTE_W-1:0] byte_cnt;
	logic [b2b_pkg::BYTE_W-1:0] offset;
	logic [b2b_pkg::BYTE_W-1:0] expected;
	logic [b2b_pkg::MATCH_W-1:0] match_cnt;
	logic [b2b_pkg::MATCH_W-1:0] threshold;
	logic first_marker;
	logic match;

	always_comb begin
		first_marker = !mode && (byte_cnt == '0) && (rx.data == b2b_pkg::OFFSET_MARKER);

		// Byte 0 in offset mode is the marker itself, so offset equals marker
		if (mode) begin
			offset = '0;
		end else if (offset_mode || first_marker) begin
			offset = b2b_pkg::OFFSET_MARKER;
		end else begin
			offset = b2b_pkg::BYTE_W'(1);
		end

		expected = byte_cnt + offset;  // Mod 256
		match = rx.valid && (rx.data == expected);
		threshold = mode ? b2b_pkg::DENSE_THRESHOLD : b2b_pkg::SPARSE_THRESHOLD;
	end

	// Counts persist across frames
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			byte_cnt <= '0;
			offset_mode <= 1'b0;
		end else if (rx.valid) begin
			byte_cnt <= byte_cnt + 1'b1;
			if (first_marker) begin
				offset_mode <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			match_cnt <= '0;
		end else if (match && (match_cnt != '1)) begin
			match_cnt <= match_cnt + 1'b1;  // Saturates
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			link_ok <= 1'b0;
		end else if (match_cnt >= threshold) begin
			link_ok <= 1'b1;
		end
	end

	// Pass only with a full count for the current mode
	a_link_ok_counted: assert property (
		@(posedge clk) disable iff (!rst_n)
		link_ok |-> (match_cnt >= threshold)
	);

endmodule

/* source/tx_pattern_source.sv */
`timescale 1ns/10ps

module tx_pattern_source (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       mode,
	input  logic                       tx_load,
	input  logic                       offset_mode,
	input  logic                       link_ok,
	input  b2b_pkg::rx_byte_t          rx,
	output logic [b2b_pkg::BYTE_W-1:0] tx_data
);

	logic [b2b_pkg::BYTE_W-1:0] dense_reg;
	logic [b2b_pkg::BYTE_W-1:0] dense_tx;
	logic [b2b_pkg::BYTE_W-1:0] sparse_cnt;

	// Offered value is one below the register, so FE goes out first
	assign dense_tx = dense_reg - 1'b1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dense_reg <= b2b_pkg::DENSE_TX_START;
		end else if (mode && tx_load) begin
			dense_reg <= dense_tx;
		end
	end

	// Holds at its start value until the link passes
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sparse_cnt <= b2b_pkg::SPARSE_TX_START;
		end else if (offset_mode && !link_ok) begin
			sparse_cnt <= b2b_pkg::OFFSET_MARKER;  // Offset start is 2
		end else if (link_ok && rx.valid) begin
			sparse_cnt <= sparse_cnt + 1'b1;
		end
	end

	assign tx_data = mode ? dense_tx : sparse_cnt;

endmodule

/* source/b2b_spi_top.sv */
`timescale 1ns/10ps

module b2b_spi_top (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               mode,  // 1 dense, 0 sparse
	input  b2b_pkg::spi_pins_t pins,
	output logic               miso,
	output logic               link_ok
);

	b2b_pkg::spi_events_t events;
	b2b_pkg::rx_byte_t rx;
	logic tx_load;
	logic [b2b_pkg::BYTE_W-1:0] tx_data;
	logic offset_mode;

	spi_pin_sync i_pin_sync (
		.clk    (clk),
		.rst_n  (rst_n),
		.pins   (pins),
		.events (events)
	);

	spi_byte_engine i_byte_engine (
		.clk     (clk),
		.rst_n   (rst_n),
		.events  (events),
		.tx_data (tx_data),
		.rx      (rx),
		.tx_load (tx_load),
		.miso    (miso)
	);

	rx_pattern_checker i_rx_checker (
		.clk         (clk),
		.rst_n       (rst_n),
		.mode        (mode),
		.rx          (rx),
		.offset_mode (offset_mode),
		.link_ok     (link_ok)
	);

	tx_pattern_source i_tx_source (
		.clk         (clk),
		.rst_n       (rst_n),
		.mode        (mode),
		.tx_load     (tx_load),
		.offset_mode (offset_mode),
		.link_ok     (link_ok),
		.rx          (rx),
		.tx_data     (tx_data)
	);

endmodule

/* sim/tb_b2b_spi.sv */
`timescale 1ns/10ps

module tb_b2b_spi;

	localparam int HALF_SCK = 4;  // clk cycles per sck half period
	localparam int RESET_CYCLES = 4;
	localparam int SETTLE_CYCLES = 8;  // Pad edge to link_ok is about 5 cycles
	localparam int MAX_SESSIONS = 16;
	localparam int MAX_BYTES = 1024;
	localparam int MAX_EXP = 4;
	localparam logic [31:0] LCG_SEED = 32'h6e50_8017;

	// One line of the golden file
	typedef struct packed {
		logic mode;
		logic rnd;
		logic link_ok;
		logic [2:0] n_exp;
		logic [9:0] nbytes;
		logic [9:0] frame_len;
		logic [9:0] exp_at;
		logic [7:0] start;
		logic [7:0] step;
		logic [3:0][7:0] exp_bytes;
	} session_t;

	logic clk;
	logic rst_n;
	logic mode;
	b2b_pkg::spi_pins_t pins;
	logic miso;
	logic link_ok;

	session_t sessions [MAX_SESSIONS];
	logic [7:0] miso_bytes [MAX_BYTES];
	int n_sessions;
	int total_bytes;
	int checks;
	int errors;
	int cycle_cnt;
	int cycle_limit;
	logic limit_set;
	logic load_ok;
	logic [31:0] lcg_state;

	b2b_spi_top i_dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.mode    (mode),
		.pins    (pins),
		.miso    (miso),
		.link_ok (link_ok)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		if (limit_set) begin
			cycle_cnt = cycle_cnt + 1;
			if (cycle_cnt > cycle_limit) begin
				$display("Timeout: the run went past %0d clock cycles", cycle_limit);
				$display("=== FAIL ===");
				$finish;
			end
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic load_golden(output logic ok);
		int fd;
		int n;
		int fields;
		string line;
		int f_mode;
		int f_nbytes;
		int f_frame;
		int f_start;
		int f_step;
		int f_rnd;
		int f_exp_at;
		int f_n_exp;
		int f_e0;
		int f_e1;
		int f_e2;
		int f_e3;
		int f_link;
		session_t s;
		ok = 1'b0;
		n_sessions = 0;
		total_bytes = 0;
		fd = $fopen("sim/b2b_golden.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the golden file sim/b2b_golden.txt");
		end else begin
			ok = 1'b1;
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 1 && line.getc(0) != "#") begin
					fields = $sscanf(line, "%d %d %d %h %h %d %d %d %h %h %h %h %d",
						f_mode, f_nbytes, f_frame, f_start, f_step, f_rnd,
						f_exp_at, f_n_exp, f_e0, f_e1, f_e2, f_e3, f_link);
					if (fields != 13 || n_sessions >= MAX_SESSIONS || f_frame < 1
							|| f_nbytes >= MAX_BYTES || f_n_exp > MAX_EXP
							|| f_exp_at + f_n_exp > f_nbytes) begin
						$display("A golden file line is malformed: %s", line);
						ok = 1'b0;
					end else begin
						s.mode = f_mode[0];
						s.rnd = f_rnd[0];
						s.link_ok = f_link[0];
						s.n_exp = f_n_exp[2:0];
						s.nbytes = f_nbytes[9:0];
						s.frame_len = f_frame[9:0];
						s.exp_at = f_exp_at[9:0];
						s.start = f_start[7:0];
						s.step = f_step[7:0];
						s.exp_bytes = {f_e3[7:0], f_e2[7:0], f_e1[7:0], f_e0[7:0]};
						sessions[n_sessions[3:0]] = s;
						n_sessions = n_sessions + 1;
						total_bytes = total_bytes + f_nbytes;
					end
				end
			end
			$fclose(fd);
			if (n_sessions == 0) begin
				$display("The golden file holds no session");
				ok = 1'b0;
			end
		end
	endtask

	// Mode changes only while reset is held
	task automatic apply_reset(input logic new_mode);
		@(posedge clk);
		rst_n <= 1'b0;
		mode <= new_mode;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		checks = checks + 2;
		assert (link_ok === 1'b0) else begin
			$display("ERR %0t: link_ok is %b after reset, expected 0", $time, link_ok);
			errors = errors + 1;
		end
		assert (miso === 1'b1) else begin
			$display("ERR %0t: miso is %b after reset, expected 1", $time, miso);
			errors = errors + 1;
		end
		repeat (HALF_SCK) @(posedge clk);  // Let the synchronizers settle
	endtask

	task automatic open_frame();
		@(posedge clk);
		pins.ssel <= 1'b0;
		repeat (HALF_SCK - 1) @(posedge clk);
	endtask

	task automatic close_frame();
		@(posedge clk);
		pins.ssel <= 1'b1;
		repeat (HALF_SCK) @(posedge clk);
	endtask

	// Mode 3 master, sck idles high, data changes on the fall
	task automatic transfer_byte(input logic [7:0] tx, output logic [7:0] rx);
		logic [7:0] shift_out;
		logic [7:0] shift_in;
		shift_out = tx;
		shift_in = 8'h00;
		repeat (8) begin
			@(posedge clk);
			pins.sck <= 1'b0;
			pins.mosi <= shift_out[7];
			shift_out = {shift_out[6:0], 1'b0};
			repeat (HALF_SCK - 1) @(posedge clk);
			@(negedge clk);
			shift_in = {shift_in[6:0], miso};  // Value seen at the rise
			@(posedge clk);
			pins.sck <= 1'b1;
			repeat (HALF_SCK - 1) @(posedge clk);
		end
		rx = shift_in;
	endtask

	task automatic run_session(input int idx);
		session_t cur;
		int sent;
		int in_frame;
		int k;
		int wait_cnt;
		int errors_before;
		logic [9:0] pos;
		logic [7:0] value;
		logic [7:0] rx_byte;
		string kind;
		cur = sessions[idx[3:0]];
		errors_before = errors;
		if (cur.mode) begin
			kind = "dense";
		end else begin
			kind = "sparse";
		end
		apply_reset(cur.mode);
		sent = 0;
		while (sent < int'(cur.nbytes)) begin
			open_frame();
			in_frame = 0;
			while (in_frame < int'(cur.frame_len) && sent < int'(cur.nbytes)) begin
				if (cur.rnd) begin
					lcg_state = lcg_next(lcg_state);
					value = lcg_state[31:24];
				end else begin
					value = cur.start + 8'(sent) * cur.step;
				end
				transfer_byte(value, rx_byte);
				miso_bytes[sent[9:0]] = rx_byte;
				sent = sent + 1;
				in_frame = in_frame + 1;
			end
			close_frame();
		end
		wait_cnt = 0;
		while (link_ok !== cur.link_ok && wait_cnt < SETTLE_CYCLES) begin
			@(negedge clk);
			wait_cnt = wait_cnt + 1;
		end
		for (k = 0; k < int'(cur.n_exp); k++) begin
			pos = cur.exp_at + k[9:0];
			checks = checks + 1;
			assert (miso_bytes[pos] === cur.exp_bytes[k[1:0]]) else begin
				$display("ERR %0t: test %0d miso byte %0d is %h, expected %h", $time,
					idx + 1, pos, miso_bytes[pos], cur.exp_bytes[k[1:0]]);
				errors = errors + 1;
			end
		end
		checks = checks + 1;
		assert (link_ok === cur.link_ok) else begin
			$display("ERR %0t: test %0d link_ok is %b, expected %b", $time, idx + 1,
				link_ok, cur.link_ok);
			errors = errors + 1;
		end
		$display("Test %0d, %s mode, %0d bytes: %0d errors", idx + 1, kind, cur.nbytes,
			errors - errors_before);
	endtask

	initial begin
		rst_n <= 1'b0;
		mode <= 1'b0;
		pins.sck <= 1'b1;
		pins.ssel <= 1'b1;
		pins.mosi <= 1'b0;
		checks = 0;
		errors = 0;
		cycle_cnt = 0;
		cycle_limit = 0;
		limit_set = 1'b0;
		lcg_state = LCG_SEED;
		load_golden(load_ok);
		if (!load_ok) begin
			$display("The golden file could not be used, no test was run");
			$display("=== FAIL ===");
		end else begin
			cycle_limit = total_bytes * 8 * 8 * 2;
			limit_set = 1'b1;
			for (int i = 0; i < n_sessions; i++) begin
				run_session(i);
			end
			$display("Done: %0d tests, %0d checks, %0d errors", n_sessions, checks, errors);
			if (errors == 0) begin
				$display("=== PASS ===");
			end else begin
				$display("=== FAIL ===");
			end
		end
		$finish;
	end

endmodule

/* b2b_spi_test.f */
source/b2b_pkg.sv
source/spi_pin_sync.sv
source/spi_byte_engine.sv
source/rx_pattern_checker.sv
source/tx_pattern_source.sv
source/b2b_spi_top.sv
sim/tb_b2b_spi.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator, run it, check $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module tb_b2b_spi -f b2b_spi_test.f -o sim_tb
	./obj_dir/sim_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* sim/b2b_golden.txt */
# mode nbytes frame_len start step random exp_at n_exp exp0 exp1 exp2 exp3 link_ok
# mode 1 dense, 0 sparse; start, step, exp0..exp3 in hex; n_exp miso bytes from exp_at on
#
# Reset values only, no bytes sent
0   0 16 00 00 0   0 0 00 00 00 00 0
#
# Dense pass, bytes 0..255, miso counts down from FE
1 256 16 00 01 0   0 4 FE FD FC FB 1
#
# Dense one byte short of the threshold
1 255 16 00 01 0 252 3 02 01 00 00 0
#
# Sparse plain, bytes i+1, miso holds at 01 before the pass
0  64 16 01 01 0   0 4 01 01 01 01 1
#
# Sparse one byte short of the threshold
0  63  8 01 01 0  59 4 01 01 01 01 0
#
# Sparse offset, first byte 02, miso moves to 02 after byte 0
0  64 16 02 01 0   1 4 02 02 02 02 1
#
# Sparse offset with one byte per frame
0  64  1 02 01 0   0 2 01 02 00 00 1
#
# Corrupted stream of random bytes
0  64 16 00 00 1   0 1 01 00 00 00 0
#
# Sparse pass, then miso counts up from the pass
0  68 16 01 01 0  64 4 01 02 03 04 1
